// ==== common/dram_pkg.sv ====
package dram_pkg;

    // Request address fields of the fixed x8 device layout
    localparam int RAM_ADDR_W = 32;
    localparam int OFFSET_W   = 3;
    localparam int COL_W      = 7;
    localparam int BANK_W     = 2;
    localparam int BG_W       = 2;
    localparam int ROW_W      = 15;
    localparam int RANK_W     = 1;

    // Field positions packed upward from the burst offset
    localparam int COL_LSB  = OFFSET_W;
    localparam int BANK_LSB = COL_LSB + COL_W;
    localparam int BG_LSB   = BANK_LSB + BANK_W;
    localparam int ROW_LSB  = BG_LSB + BG_W;
    localparam int RANK_LSB = ROW_LSB + ROW_W;

    // Row table covers every bank of every bank group
    localparam int BANK_IDX_W = BG_W + BANK_W;
    localparam int NUM_BANKS  = 1 << BANK_IDX_W;

    // Timing in clock cycles and shortened for simulation
    localparam int T_RCD       = 4;
    localparam int T_RP        = 4;
    localparam int T_CL        = 5;
    localparam int T_CWL       = 4;
    localparam int T_BURST     = 4;
    localparam int T_WR        = 6;
    localparam int T_RFC       = 10;
    localparam int T_REFI      = 300;
    localparam int T_INIT_PU   = 20;
    localparam int T_INIT_STEP = 4;

    // Wide enough for the longest interval
    localparam int CNT_W = $clog2(T_REFI + 1);

    typedef enum logic [3:0] {
        POWER_UP,
        RESET_EXIT,
        LOAD_MODE,
        ZQ_CAL,
        IDLE,
        ACTIVATE,
        READ,
        WRITE,
        PRECHARGE,
        REFRESH
    } dram_state_t;

    typedef enum logic [1:0] {
        ROW_NONE     = 2'b00,
        ROW_HIT      = 2'b01,
        ROW_EMPTY    = 2'b10,
        ROW_CONFLICT = 2'b11
    } row_stat_t;

endpackage

// ==== verilog/addr_mapper.sv ====
`timescale 1ns/1ps

module addr_mapper (
    input  logic [dram_pkg::RAM_ADDR_W-1:0] ram_addr,
    output logic [dram_pkg::OFFSET_W-1:0]   offset,
    output logic [dram_pkg::COL_W-1:0]      col,
    output logic [dram_pkg::BANK_W-1:0]     bank,
    output logic [dram_pkg::BG_W-1:0]       bg,
    output logic [dram_pkg::ROW_W-1:0]      row,
    output logic [dram_pkg::RANK_W-1:0]     rank
);
    import dram_pkg::*;

    // x8 layout from low to high is offset, column, bank, bank group, row, rank
    // Address bits above the rank field are not decoded
    always_comb begin
        offset = ram_addr[OFFSET_W-1:0];
        col    = ram_addr[COL_LSB +: COL_W];
        bank   = ram_addr[BANK_LSB +: BANK_W];
        bg     = ram_addr[BG_LSB +: BG_W];
        row    = ram_addr[ROW_LSB +: ROW_W];
        rank   = ram_addr[RANK_LSB +: RANK_W];
    end

endmodule

// ==== verilog/row_open.sv ====
`timescale 1ns/1ps

module row_open (
    input  logic                        CLK,
    input  logic                        nRST,
    input  logic [dram_pkg::BG_W-1:0]   bg,
    input  logic [dram_pkg::BANK_W-1:0] bank,
    input  logic [dram_pkg::ROW_W-1:0]  row,
    input  logic                        req_en,
    input  logic                        row_resolve,
    input  logic                        refresh,
    output dram_pkg::row_stat_t         row_stat,
    output logic [dram_pkg::ROW_W-1:0]  row_conflict
);
    import dram_pkg::*;

    logic [NUM_BANKS-1:0]  row_valid;
    logic [ROW_W-1:0]      open_row [NUM_BANKS];
    logic [BANK_IDX_W-1:0] bank_idx;

    assign bank_idx = {bg, bank};

    // All banks closed after reset and after refresh
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            row_valid <= '0;
        end else if (refresh) begin
            row_valid <= '0;
        end else if (row_resolve) begin
            row_valid[bank_idx] <= 1'b1;
        end
    end

    // Row stored on activate
    always_ff @(posedge CLK) begin
        if (row_resolve) begin
            open_row[bank_idx] <= row;
        end
    end

    assign row_conflict = open_row[bank_idx];

    always_comb begin
        if (!req_en) begin
            row_stat = ROW_NONE;
        end else if (!row_valid[bank_idx]) begin
            row_stat = ROW_EMPTY;
        end else if (open_row[bank_idx] == row) begin
            row_stat = ROW_HIT;
        end else begin
            row_stat = ROW_CONFLICT;
        end
    end

endmodule

// ==== verilog/init_state.sv ====
`timescale 1ns/1ps

module init_state (
    input  logic                  CLK,
    input  logic                  nRST,
    input  logic                  init,
    output logic                  init_done,
    output dram_pkg::dram_state_t init_state,
    output dram_pkg::dram_state_t ninit_state
);
    import dram_pkg::*;

    logic [CNT_W-1:0] step_cnt;
    logic [CNT_W-1:0] nstep_cnt;
    logic             ninit_done;

    // Counter starts loaded with the power-up wait
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            init_state <= POWER_UP;
            step_cnt   <= CNT_W'(T_INIT_PU - 1);
            init_done  <= 1'b0;
        end else begin
            init_state <= ninit_state;
            step_cnt   <= nstep_cnt;
            init_done  <= ninit_done;
        end
    end

    always_comb begin
        ninit_state = init_state;
        nstep_cnt   = step_cnt;
        ninit_done  = init_done;
        if (init && !init_done) begin
            if (step_cnt != '0) begin
                nstep_cnt = step_cnt - 1'b1;
            end else begin
                // Each mode-setting step gets the same spacing
                nstep_cnt = CNT_W'(T_INIT_STEP - 1);
                case (init_state)
                    POWER_UP:   ninit_state = RESET_EXIT;
                    RESET_EXIT: ninit_state = LOAD_MODE;
                    LOAD_MODE:  ninit_state = ZQ_CAL;
                    ZQ_CAL: begin
                        ninit_state = IDLE;
                        ninit_done  = 1'b1;
                    end
                    default:    ninit_state = IDLE;
                endcase
            end
        end
    end

endmodule

// ==== verilog/command_fsm.sv ====
`timescale 1ns/1ps

module command_fsm (
    input  logic                  CLK,
    input  logic                  nRST,
    input  logic                  dren,
    input  logic                  dwen,
    input  logic                  init_done,
    input  dram_pkg::row_stat_t   row_stat,
    input  logic                  tact_done,
    input  logic                  tpre_done,
    input  logic                  trd_done,
    input  logic                  twr_done,
    input  logic                  tref_done,
    input  logic                  rf_req,
    output logic                  init_req,
    output logic                  row_resolve,
    output logic                  refresh,
    output logic                  ram_wait,
    output dram_pkg::dram_state_t cmd_state,
    output dram_pkg::dram_state_t ncmd_state
);
    import dram_pkg::*;

    // Pending write remembered across PRECHARGE and ACTIVATE
    logic wr_op;
    logic nwr_op;
    // Current PRECHARGE closes all banks ahead of REFRESH
    logic ref_pend;
    logic nref_pend;
    logic req;
    logic access_end;

    assign req = dren | dwen;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            cmd_state <= IDLE;
            wr_op     <= 1'b0;
            ref_pend  <= 1'b0;
        end else begin
            cmd_state <= ncmd_state;
            wr_op     <= nwr_op;
            ref_pend  <= nref_pend;
        end
    end

    always_comb begin
        ncmd_state = cmd_state;
        nwr_op     = wr_op;
        nref_pend  = ref_pend;
        case (cmd_state)
            IDLE: begin
                if (init_done) begin
                    // Refresh wins over a waiting request
                    if (rf_req) begin
                        ncmd_state = PRECHARGE;
                        nref_pend  = 1'b1;
                    end else if (req) begin
                        nwr_op = dwen;
                        case (row_stat)
                            ROW_CONFLICT: ncmd_state = PRECHARGE;
                            ROW_EMPTY:    ncmd_state = ACTIVATE;
                            ROW_HIT:      ncmd_state = dwen ? WRITE : READ;
                            default:      ncmd_state = IDLE;
                        endcase
                    end
                end
            end
            PRECHARGE: begin
                if (tpre_done) begin
                    ncmd_state = ref_pend ? REFRESH : ACTIVATE;
                    nref_pend  = 1'b0;
                end
            end
            ACTIVATE: begin
                if (tact_done) begin
                    ncmd_state = wr_op ? WRITE : READ;
                end
            end
            READ: begin
                if (trd_done) begin
                    ncmd_state = IDLE;
                end
            end
            WRITE: begin
                if (twr_done) begin
                    ncmd_state = IDLE;
                end
            end
            REFRESH: begin
                if (tref_done) begin
                    ncmd_state = IDLE;
                end
            end
            default: ncmd_state = IDLE;
        endcase
    end

    assign init_req = !init_done;

    // One pulse on entry to ACTIVATE records the new row
    assign row_resolve = (ncmd_state == ACTIVATE) && (cmd_state != ACTIVATE);

    // Table is cleared as the all-bank precharge completes
    assign refresh = (cmd_state == PRECHARGE) && ref_pend && tpre_done;

    // Stall drops only on the last cycle of an access
    assign access_end = ((cmd_state == READ) && trd_done)
                     || ((cmd_state == WRITE) && twr_done);
    assign ram_wait = !access_end;

endmodule

// ==== verilog/timing_signal.sv ====
`timescale 1ns/1ps

module timing_signal (
    input  logic                  CLK,
    input  logic                  nRST,
    input  logic                  init_done,
    input  dram_pkg::dram_state_t cmd_state,
    output logic                  tact_done,
    output logic                  tpre_done,
    output logic                  trd_done,
    output logic                  twr_done,
    output logic                  tref_done,
    output logic                  rf_req,
    output logic                  rd_en,
    output logic                  wr_en,
    output logic                  clear
);
    import dram_pkg::*;

    dram_state_t      state_q;
    logic [CNT_W-1:0] cnt;
    // Zero-based cycle index within the current state
    logic [CNT_W-1:0] idx;
    logic [CNT_W-1:0] refi_cnt;

    assign idx = (cmd_state != state_q) ? '0 : cnt;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state_q <= IDLE;
            cnt     <= '0;
        end else begin
            state_q <= cmd_state;
            cnt     <= idx + 1'b1;
        end
    end

    assign tact_done = (cmd_state == ACTIVATE)  && (idx == CNT_W'(T_RCD - 1));
    assign tpre_done = (cmd_state == PRECHARGE) && (idx == CNT_W'(T_RP - 1));
    assign trd_done  = (cmd_state == READ)      && (idx == CNT_W'(T_CL + T_BURST - 1));
    assign twr_done  = (cmd_state == WRITE)
                    && (idx == CNT_W'(T_CWL + T_BURST + T_WR - 1));
    assign tref_done = (cmd_state == REFRESH)   && (idx == CNT_W'(T_RFC - 1));

    // Burst windows follow the read and write latencies
    assign rd_en = (cmd_state == READ) && (idx >= CNT_W'(T_CL));
    assign wr_en = (cmd_state == WRITE) && (idx >= CNT_W'(T_CWL))
                && (idx < CNT_W'(T_CWL + T_BURST));

    assign clear = trd_done | twr_done;

    // Refresh interval restarts when REFRESH is entered
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            refi_cnt <= '0;
            rf_req   <= 1'b0;
        end else if (!init_done || (cmd_state == REFRESH)) begin
            refi_cnt <= '0;
            rf_req   <= 1'b0;
        end else if (!rf_req) begin
            if (refi_cnt == CNT_W'(T_REFI - 1)) begin
                rf_req <= 1'b1;
            end else begin
                refi_cnt <= refi_cnt + 1'b1;
            end
        end
    end

endmodule

// ==== verilog/control_unit.sv ====
`timescale 1ns/1ps

module control_unit (
    input  logic                                      CLK,
    input  logic                                      nRST,
    input  logic                                      dren,
    input  logic                                      dwen,
    input  logic [dram_pkg::RAM_ADDR_W-1:0]           ram_addr,
    output logic                                      ram_wait,
    output logic                                      rd_en,
    output logic                                      wr_en,
    output logic                                      clear,
    output logic [dram_pkg::OFFSET_W-1:0]             offset,
    output dram_pkg::dram_state_t                     state,
    output dram_pkg::dram_state_t                     nstate,
    output logic [dram_pkg::RANK_W-1:0]               rank,
    output logic [dram_pkg::BG_W-1:0]                 bg,
    output logic [dram_pkg::BANK_W-1:0]               bank,
    output logic [dram_pkg::ROW_W-1:0]                row,
    output logic [dram_pkg::COL_W+dram_pkg::OFFSET_W-1:0] col,
    output logic                                      rf_req
);
    import dram_pkg::*;

    logic [COL_W-1:0] col_idx;
    logic [ROW_W-1:0] req_row;
    logic [ROW_W-1:0] row_conflict;
    row_stat_t        row_stat;
    logic             req_en;

    logic             init_req;
    logic             init_done;
    logic             init_done_q;
    dram_state_t      init_st;
    dram_state_t      ninit_st;
    dram_state_t      cmd_state;
    dram_state_t      ncmd_state;

    logic             row_resolve;
    logic             refresh;
    logic             tact_done;
    logic             tpre_done;
    logic             trd_done;
    logic             twr_done;
    logic             tref_done;

    assign req_en = dren | dwen;

    addr_mapper u_addr (
        .ram_addr (ram_addr),
        .offset   (offset),
        .col      (col_idx),
        .bank     (bank),
        .bg       (bg),
        .row      (req_row),
        .rank     (rank)
    );

    row_open u_row (
        .CLK          (CLK),
        .nRST         (nRST),
        .bg           (bg),
        .bank         (bank),
        .row          (req_row),
        .req_en       (req_en),
        .row_resolve  (row_resolve),
        .refresh      (refresh),
        .row_stat     (row_stat),
        .row_conflict (row_conflict)
    );

    init_state u_init (
        .CLK         (CLK),
        .nRST        (nRST),
        .init        (init_req),
        .init_done   (init_done),
        .init_state  (init_st),
        .ninit_state (ninit_st)
    );

    command_fsm u_cmd (
        .CLK         (CLK),
        .nRST        (nRST),
        .dren        (dren),
        .dwen        (dwen),
        .init_done   (init_done),
        .row_stat    (row_stat),
        .tact_done   (tact_done),
        .tpre_done   (tpre_done),
        .trd_done    (trd_done),
        .twr_done    (twr_done),
        .tref_done   (tref_done),
        .rf_req      (rf_req),
        .init_req    (init_req),
        .row_resolve (row_resolve),
        .refresh     (refresh),
        .ram_wait    (ram_wait),
        .cmd_state   (cmd_state),
        .ncmd_state  (ncmd_state)
    );

    timing_signal u_time (
        .CLK       (CLK),
        .nRST      (nRST),
        .init_done (init_done),
        .cmd_state (cmd_state),
        .tact_done (tact_done),
        .tpre_done (tpre_done),
        .trd_done  (trd_done),
        .twr_done  (twr_done),
        .tref_done (tref_done),
        .rf_req    (rf_req),
        .rd_en     (rd_en),
        .wr_en     (wr_en),
        .clear     (clear)
    );

    // Source switch happens one cycle after init reaches IDLE
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            init_done_q <= 1'b0;
        end else begin
            init_done_q <= init_done;
        end
    end

    always_comb begin
        if (!init_done_q) begin
            state  = init_st;
            nstate = ninit_st;
        end else begin
            state  = cmd_state;
            nstate = ncmd_state;
        end
    end

    assign col = {col_idx, offset};

    // On a conflict the precharge must target the row still open
    assign row = (row_stat == ROW_CONFLICT) ? row_conflict : req_row;

endmodule

// ==== tb/tb_control_unit.sv ====
`timescale 1ns/1ps

module tb_control_unit;
    import dram_pkg::*;

    localparam int INIT_TIMEOUT   = 200;
    localparam int ACCESS_TIMEOUT = 100;
    localparam int REFI_TIMEOUT   = T_REFI + 100;

    logic                      CLK;
    logic                      nRST;
    logic                      dren;
    logic                      dwen;
    logic [RAM_ADDR_W-1:0]     ram_addr;
    logic                      ram_wait;
    logic                      rd_en;
    logic                      wr_en;
    logic                      clear;
    logic [OFFSET_W-1:0]       offset;
    dram_state_t               state;
    dram_state_t               nstate;
    logic [RANK_W-1:0]         rank;
    logic [BG_W-1:0]           bg;
    logic [BANK_W-1:0]         bank;
    logic [ROW_W-1:0]          row;
    logic [COL_W+OFFSET_W-1:0] col;
    logic                      rf_req;

    // Reference model of the open rows indexed by {bg, bank}
    logic [NUM_BANKS-1:0]      open_valid;
    logic [ROW_W-1:0]          open_row [NUM_BANKS];
    int                        n_access;
    int                        cycle_cnt = 0;
    // Cycle from which the refresh interval runs
    int                        refi_start;

    control_unit dut0 (
        .CLK      (CLK),
        .nRST     (nRST),
        .dren     (dren),
        .dwen     (dwen),
        .ram_addr (ram_addr),
        .ram_wait (ram_wait),
        .rd_en    (rd_en),
        .wr_en    (wr_en),
        .clear    (clear),
        .offset   (offset),
        .state    (state),
        .nstate   (nstate),
        .rank     (rank),
        .bg       (bg),
        .bank     (bank),
        .row      (row),
        .col      (col),
        .rf_req   (rf_req)
    );

    initial begin
        CLK = 1'b0;
        forever #5 CLK = ~CLK;
    end

    always @(posedge CLK) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Some tests failed");
        $fatal(1, "Run aborted");
    endtask

    task automatic report_error(input string msg);
        abort_run($sformatf("CHECK FAILED at time %0t: %s", $time, msg));
    endtask

    task automatic watch_init();
        dram_state_t seq [5] = '{POWER_UP, RESET_EXIT, LOAD_MODE, ZQ_CAL, IDLE};
        int          dur [4] = '{T_INIT_PU, T_INIT_STEP, T_INIT_STEP, T_INIT_STEP};
        dram_state_t exp_next;
        int          idx;
        int          in_state;
        int          cycles;

        idx      = 0;
        in_state = 0;
        cycles   = 0;
        while (idx < 4) begin
            @(posedge CLK);
            cycles++;
            if (cycles > INIT_TIMEOUT) begin
                abort_run("Timed out waiting for the init sequence to reach IDLE");
            end
            assert (ram_wait && !rd_en && !wr_en && !rf_req && !clear)
                else report_error("control outputs active during init");
            if (state == seq[idx + 1]) begin
                assert (in_state == dur[idx])
                    else report_error($sformatf("init step before %s lasted %0d cycles",
                                                state.name(), in_state));
                idx++;
                in_state = 0;
            end else begin
                assert (state == seq[idx])
                    else report_error($sformatf("init state %s out of order", state.name()));
            end
            // Next state turns over on the last cycle of each step
            exp_next = seq[idx];
            if (idx < 4) begin
                if (in_state == dur[idx] - 1) begin
                    exp_next = seq[idx + 1];
                end
            end
            assert (nstate == exp_next)
                else report_error($sformatf("init nstate %s, expected %s",
                                            nstate.name(), exp_next.name()));
            in_state++;
        end
        refi_start = cycle_cnt;
    endtask

    task automatic perform_access(
        input logic [7:0]                op,
        input logic [RAM_ADDR_W-1:0]     addr,
        input logic [7:0]                cls,
        input logic [RANK_W-1:0]         e_rank,
        input logic [BG_W-1:0]           e_bg,
        input logic [BANK_W-1:0]         e_bank,
        input logic [ROW_W-1:0]          e_row,
        input logic [COL_W+OFFSET_W-1:0] e_col
    );
        logic [BANK_IDX_W-1:0] idx;
        dram_state_t           first_cmd;
        dram_state_t           last_state;
        dram_state_t           exp_last;
        logic                  seen_act;
        logic                  seen_pre;
        logic                  done;
        int                    rd_cnt;
        int                    wr_cnt;
        int                    cycles;

        idx        = {e_bg, e_bank};
        first_cmd  = IDLE;
        last_state = IDLE;
        exp_last   = (op == "W") ? WRITE : READ;
        seen_act   = 1'b0;
        seen_pre   = 1'b0;
        done       = 1'b0;
        rd_cnt     = 0;
        wr_cnt     = 0;
        cycles     = 0;
        if (op != "R" && op != "W") begin
            abort_run($sformatf("Unknown operation in stimulus line %0d", n_access));
        end

        @(negedge CLK);
        dren     = (op == "R");
        dwen     = (op == "W");
        ram_addr = addr;
        while (!done) begin
            @(posedge CLK);
            cycles++;
            if (cycles > ACCESS_TIMEOUT) begin
                abort_run($sformatf("Timed out waiting for ram_wait low on access %0d",
                                    n_access));
            end
            assert (rank == e_rank && bg == e_bg && bank == e_bank && col == e_col
                    && offset == e_col[OFFSET_W-1:0])
                else report_error($sformatf("access %0d decoded fields differ", n_access));
            if (first_cmd == IDLE && state != IDLE) begin
                first_cmd = state;
            end
            if (state == ACTIVATE) begin
                seen_act = 1'b1;
            end
            if (state == PRECHARGE) begin
                seen_pre = 1'b1;
                if (cls == "C") begin
                    assert (open_valid[idx] && row == open_row[idx])
                        else report_error($sformatf("precharge row %h, expected %h",
                                                    row, open_row[idx]));
                end
            end
            if (state == READ || state == WRITE) begin
                assert (row == e_row)
                    else report_error($sformatf("access row %h, expected %h", row, e_row));
            end
            if (rd_en) begin
                rd_cnt++;
            end
            if (wr_en) begin
                wr_cnt++;
            end
            if (!ram_wait) begin
                done       = 1'b1;
                last_state = state;
                assert (clear) else report_error("clear low on the completing cycle");
            end else begin
                assert (!clear) else report_error("clear high while ram_wait is high");
            end
        end
        @(negedge CLK);
        dren = 1'b0;
        dwen = 1'b0;

        assert (last_state == exp_last)
            else report_error($sformatf("access %0d ended in %s", n_access, last_state.name()));
        case (cls)
            "E": assert (first_cmd == ACTIVATE && !seen_pre)
                else report_error($sformatf("access %0d not handled as empty bank", n_access));
            "H": assert (first_cmd == exp_last && !seen_act && !seen_pre)
                else report_error($sformatf("access %0d not handled as row hit", n_access));
            "C": assert (first_cmd == PRECHARGE && seen_act)
                else report_error($sformatf("access %0d not handled as conflict", n_access));
            default: abort_run($sformatf("Unknown class in stimulus line %0d", n_access));
        endcase
        if (op == "W") begin
            assert (wr_cnt == T_BURST && rd_cnt == 0)
                else report_error($sformatf("write strobes rd %0d wr %0d", rd_cnt, wr_cnt));
        end else begin
            assert (rd_cnt == T_BURST && wr_cnt == 0)
                else report_error($sformatf("read strobes rd %0d wr %0d", rd_cnt, wr_cnt));
        end

        open_valid[idx] = 1'b1;
        open_row[idx]   = e_row;
        n_access++;
    endtask

    task automatic idle_until_refresh();
        logic seen_req;
        logic seen_pre;
        logic seen_ref;
        logic done;
        int   cycles;

        seen_req = 1'b0;
        seen_pre = 1'b0;
        seen_ref = 1'b0;
        done     = 1'b0;
        cycles   = 0;
        while (!done) begin
            @(posedge CLK);
            cycles++;
            if (cycles > REFI_TIMEOUT) begin
                abort_run("Timed out waiting for a refresh after idle time");
            end
            assert (ram_wait && !rd_en && !wr_en && !clear)
                else report_error("stall or data strobes wrong while idle");
            if (rf_req && !seen_req) begin
                seen_req = 1'b1;
                assert ((cycle_cnt - refi_start) >= T_REFI
                        && (cycle_cnt - refi_start) <= T_REFI + 2)
                    else report_error($sformatf("rf_req after %0d cycles",
                                                cycle_cnt - refi_start));
            end
            if (state == PRECHARGE) begin
                seen_pre = 1'b1;
                assert (seen_req) else report_error("precharge without rf_req");
            end
            if (state == REFRESH) begin
                seen_ref = 1'b1;
                assert (seen_pre) else report_error("REFRESH without all-bank PRECHARGE");
            end
            done = seen_ref && (state == IDLE);
        end
        refi_start = cycle_cnt;
        // All banks are closed by the refresh
        open_valid = '0;
    endtask

    initial begin
        int                        fd;
        int                        n;
        string                     line;
        logic [7:0]                op;
        logic [7:0]                cls;
        logic [RAM_ADDR_W-1:0]     addr;
        logic [RANK_W-1:0]         e_rank;
        logic [BG_W-1:0]           e_bg;
        logic [BANK_W-1:0]         e_bank;
        logic [ROW_W-1:0]          e_row;
        logic [COL_W+OFFSET_W-1:0] e_col;

        nRST       = 1'b0;
        dren       = 1'b0;
        dwen       = 1'b0;
        ram_addr   = '0;
        open_valid = '0;
        n_access   = 0;
        refi_start = 0;

        fd = $fopen("tb/control_unit_stim.txt", "r");
        if (fd == 0) begin
            abort_run("Cannot open stimulus file tb/control_unit_stim.txt");
        end

        repeat (10) @(posedge CLK);
        assert (state == POWER_UP && ram_wait && !rd_en && !wr_en && !rf_req && !clear)
            else report_error("outputs not at reset values");
        @(negedge CLK);
        nRST = 1'b1;
        watch_init();

        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() < 2 || line[0] == "#") begin
                continue;
            end
            n = $sscanf(line, "%c %h %c %h %h %h %h %h",
                        op, addr, cls, e_rank, e_bg, e_bank, e_row, e_col);
            if (n != 8) begin
                abort_run($sformatf("Malformed stimulus line: %s", line));
            end
            if (op == "I") begin
                idle_until_refresh();
            end else begin
                perform_access(op, addr, cls, e_rank, e_bg, e_bank, e_row, e_col);
            end
        end
        $fclose(fd);

        assert (n_access > 0) else report_error("no accesses in stimulus file");
        $display("All tests passed");
        $finish;
    end

endmodule

// ==== tb/control_unit_stim.txt ====
# op addr class rank bg bank row col, all numbers hex
# op R read, W write, I idle until refresh; class H hit, E empty bank, C conflict, N none
R 00004008 E 0 0 0 0001 008
R 00004010 H 0 0 0 0001 010
W 0048DBF5 E 0 1 2 0123 3F5
W 0048D840 H 0 1 2 0123 040
R 01159801 C 0 1 2 0456 001
W 3FFFC2A3 C 1 0 0 7FFF 2A3
R CAAABD55 E 0 3 3 2AAA 155
R 0AAABC00 H 0 3 3 2AAA 000
I 00000000 N 0 0 0 0000 000
R 00004008 E 0 0 0 0001 008
W 0048DBF5 E 0 1 2 0123 3F5
W 000083FF C 0 0 0 0002 3FF
R 000083FF H 0 0 0 0002 3FF
R 040024C8 E 0 2 1 1000 0C8
W 040024C9 H 0 2 1 1000 0C9
R 20006410 C 1 2 1 0001 010
W 0AAABD55 E 0 3 3 2AAA 155

// ==== verilog.f ====
common/dram_pkg.sv
verilog/addr_mapper.sv
verilog/row_open.sv
verilog/init_state.sv
verilog/command_fsm.sv
verilog/timing_signal.sv
verilog/control_unit.sv
tb/tb_control_unit.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_control_unit
FILELIST = verilog.f
OBJ_DIR  = obj_dir
BIN      = $(OBJ_DIR)/V$(TOP)
SOURCES  = $(shell cat $(FILELIST))

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "All tests passed"

clean:
	rm -rf $(OBJ_DIR)
